/* batchEstimator.f */
src/batchEstimatorPkg.sv
src/batchSequencer.sv
src/sampleStore.sv
src/lookbackRecursion.sv
src/lookaheadRecursion.sv
src/partialResultStore.sv
src/estimateCombiner.sv
src/batchEstimator.sv
testbench/batchEstimatorTb.sv

/* Makefile */
# Verilator build, run and lint for the batch estimator

TOP       ?= batchEstimatorTb
RTL_TOP   ?= batchEstimator
FILELIST  ?= batchEstimator.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only -Wall

SOURCES      := $(shell grep -v '^+' $(FILELIST))
LINT_SOURCES := $(filter src/%,$(SOURCES))
BIN          := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# The log decides pass or fail
run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Test OK" $(LOG); then \
		echo "No pass message in $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(LINT_SOURCES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/batchEstimatorTb.sv */
`timescale 1ns/1ps

module batchEstimatorTb
    import batchEstimatorPkg::*;
();

    localparam logic [31:0] rngSeed = 32'h2b6bb6c9;
    localparam int numBatches = 18;
    localparam int checkBatches = 16;
    localparam int checkLen = checkBatches * batchLen;
    // Batch twinBatch + 2 repeats twinBatch, the batch after it is inverted
    localparam int twinBatch = 8;
    localparam int doneTimeout = 200;

    logic                clkDS = 1'b0;
    logic                rst;
    logic [numCtrl-1:0]  controlBits;
    logic [outWidth-1:0] estimate;
    logic                valid;

    logic [numCtrl-1:0]         stim [$];
    logic signed [outWidth-1:0] fwdPart [checkLen];
    logic signed [outWidth-1:0] bwdPart [checkLen];
    logic [outWidth-1:0]        expected [checkLen];

    int mismatchErrors = 0;
    int otherErrors = 0;
    int outCount = 0;
    int edgeCount = 0;
    bit started = 1'b0;
    bit validSeen = 1'b0;

    batchEstimator i_batchEstimator (
        .clkDS       (clkDS),
        .rst         (rst),
        .controlBits (controlBits),
        .estimate    (estimate),
        .valid       (valid)
    );

    always #5 clkDS = ~clkDS;

    // Signed range of an estimate
    function automatic logic signed [outWidth-1:0] clampOut(input longint value);
        longint hi;
        longint lo;
        longint c;
        hi = (longint'(1) << (outWidth - 1)) - 1;
        lo = -(longint'(1) << (outWidth - 1));
        c = value;
        if (c > hi) begin
            c = hi;
        end else if (c < lo) begin
            c = lo;
        end
        return c[outWidth-1:0];
    endfunction

    // Pole product in Q10, then one gain per control bit
    function automatic logic signed [stateWidth-1:0] stepState(
        input logic signed [stateWidth-1:0]       state,
        input longint                             pole,
        input logic [numCtrl-1:0][stateWidth-1:0] gain,
        input logic [numCtrl-1:0]                 ctrl
    );
        longint acc;
        acc = (longint'(state) * pole) >>> fracBits;
        for (int k = 0; k < numCtrl; k++) begin
            if (ctrl[k]) begin
                acc = acc + longint'($signed(gain[k]));
            end else begin
                acc = acc - longint'($signed(gain[k]));
            end
        end
        return acc[stateWidth-1:0];
    endfunction

    function automatic logic signed [outWidth-1:0] partialOf(
        input logic signed [stateWidth-1:0] state
    );
        return clampOut(longint'(state) >>> scaleShift);
    endfunction

    // Saturated sum moved up by half the range
    function automatic logic [outWidth-1:0] offsetCode(
        input logic signed [outWidth-1:0] fwd,
        input logic signed [outWidth-1:0] bwd
    );
        longint code;
        code = longint'(clampOut(longint'(fwd) + longint'(bwd))) + (longint'(1) << (outWidth - 1));
        return code[outWidth-1:0];
    endfunction

    task automatic buildStimulus();
        logic [numCtrl-1:0] sample;
        for (int b = 0; b < numBatches; b++) begin
            for (int j = 0; j < batchLen; j++) begin
                if (b == 4 || b == 5) begin
                    sample = '1;
                end else if (b == 6 || b == 7) begin
                    sample = '0;
                end else if (b == twinBatch + 2) begin
                    sample = stim[twinBatch * batchLen + j];
                end else if (b == twinBatch + 3) begin
                    sample = ~stim[(twinBatch + 1) * batchLen + j];
                end else begin
                    sample = numCtrl'($urandom());
                end
                stim.push_back(sample);
            end
        end
    endtask

    task automatic buildModel();
        logic signed [stateWidth-1:0] fwdState;
        logic signed [stateWidth-1:0] bwdState;
        // Forward chain never restarts
        fwdState = '0;
        for (int k = 0; k < checkLen; k++) begin
            fwdPart[k] = partialOf(fwdState);
            fwdState = stepState(fwdState, longint'(fwdPole), fwdGain, stim[k]);
        end
        // Warm up on the next batch reversed, then run this batch reversed
        for (int a = 0; a < checkBatches; a++) begin
            bwdState = '0;
            for (int j = batchLen - 1; j >= 0; j--) begin
                bwdState = stepState(bwdState, longint'(bwdPole), bwdGain,
                                     stim[(a + 1) * batchLen + j]);
            end
            for (int j = batchLen - 1; j >= 0; j--) begin
                bwdState = stepState(bwdState, longint'(bwdPole), bwdGain, stim[a * batchLen + j]);
                bwdPart[a * batchLen + j] = partialOf(bwdState);
            end
        end
        for (int k = 0; k < checkLen; k++) begin
            expected[k] = offsetCode(fwdPart[k], bwdPart[k]);
        end
    endtask

    // The stimulus has to reach saturation, carry and lookahead cases
    task automatic checkStimulusReach();
        int fwdHigh;
        int fwdLow;
        int bwdHigh;
        int bwdLow;
        int sumHigh;
        int sumLow;
        int twinDiff;
        int carried;
        fwdHigh = 0;
        fwdLow = 0;
        bwdHigh = 0;
        bwdLow = 0;
        sumHigh = 0;
        sumLow = 0;
        twinDiff = 0;
        carried = 0;
        for (int k = 0; k < checkLen; k++) begin
            fwdHigh += (fwdPart[k] == clampOut(longint'(1) << 40)) ? 1 : 0;
            fwdLow += (fwdPart[k] == clampOut(-(longint'(1) << 40))) ? 1 : 0;
            bwdHigh += (bwdPart[k] == clampOut(longint'(1) << 40)) ? 1 : 0;
            bwdLow += (bwdPart[k] == clampOut(-(longint'(1) << 40))) ? 1 : 0;
            sumHigh += (expected[k] == '1) ? 1 : 0;
            sumLow += (expected[k] == '0) ? 1 : 0;
        end
        for (int j = 0; j < batchLen; j++) begin
            twinDiff += (bwdPart[twinBatch * batchLen + j]
                         != bwdPart[(twinBatch + 2) * batchLen + j]) ? 1 : 0;
        end
        for (int b = 1; b < checkBatches; b++) begin
            carried += (fwdPart[b * batchLen] != 0) ? 1 : 0;
        end
        saturationReach: assert (fwdHigh > 0 && fwdLow > 0 && bwdHigh > 0 && bwdLow > 0
                                 && sumHigh > 0 && sumLow > 0)
            else begin
                otherErrors++;
                $display("Stimulus does not drive every partial and the sum to both limits");
            end
        lookaheadReach: assert (twinDiff > 0)
            else begin
                otherErrors++;
                $display("Repeated batches give the same backward partials");
            end
        carryReach: assert (carried > 0)
            else begin
                otherErrors++;
                $display("No batch starts with a nonzero forward state");
            end
    endtask

    // Outputs are sampled on the falling edge, away from the driving edge
    always @(negedge clkDS) begin
        if (!started || edgeCount == 0) begin
            resetValues: assert (valid == 1'b0 && estimate == '0)
                else begin
                    mismatchErrors++;
                    $display("MISMATCH at %0t: valid=%b estimate=%h after reset",
                             $time, valid, estimate);
                end
        end
        if (started) begin
            if (valid && !validSeen) begin
                validSeen = 1'b1;
                latency: assert (edgeCount == estimateLatency)
                    else begin
                        mismatchErrors++;
                        $display("MISMATCH at %0t: valid rose after %0d cycles, expected %0d",
                                 $time, edgeCount, estimateLatency);
                    end
            end
            if (validSeen) begin
                validHeld: assert (valid)
                    else begin
                        otherErrors++;
                        $display("valid went low again at %0t", $time);
                    end
            end
            if (valid && outCount < checkLen) begin
                estimateValue: assert (estimate === expected[outCount])
                    else begin
                        mismatchErrors++;
                        $display("MISMATCH at %0t: batch %0d index %0d estimate %h, expected %h",
                                 $time, outCount / batchLen, outCount % batchLen,
                                 estimate, expected[outCount]);
                    end
                outCount++;
            end
            edgeCount++;
        end
    end

    initial begin
        int waitCycles;
        rst = 1'b0;
        controlBits = '0;
        void'($urandom(rngSeed));
        buildStimulus();
        buildModel();
        checkStimulusReach();

        // Fourth reset edge releases rst and brings the first sample
        repeat (4) @(posedge clkDS);
        rst <= 1'b1;
        controlBits <= stim[0];
        started = 1'b1;
        for (int k = 1; k < stim.size(); k++) begin
            @(posedge clkDS);
            controlBits <= stim[k];
        end

        waitCycles = 0;
        while (outCount < checkLen && waitCycles < doneTimeout) begin
            @(posedge clkDS);
            waitCycles++;
        end
        if (outCount < checkLen) begin
            otherErrors++;
            $display("Timed out with %0d of %0d estimates checked", outCount, checkLen);
        end

        $display("Errors: %0d mismatches, %0d other", mismatchErrors, otherErrors);
        if (mismatchErrors + otherErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* src/batchEstimator.sv */
`timescale 1ns/1ps

module batchEstimator
    import batchEstimatorPkg::*;
(
    input  logic                clkDS,
    input  logic                rst,
    input  logic [numCtrl-1:0]  controlBits,
    output logic [outWidth-1:0] estimate,
    output logic                valid
);

    sampleAddr_t                wrAddr;
    sampleAddr_t                lhAddr;
    sampleAddr_t                brAddr;
    sampleAddr_t                frAddr;
    logic [numCtrl-1:0]         lhSample;
    logic [numCtrl-1:0]         brSample;
    logic [numCtrl-1:0]         frSample;
    logic                       resBank;
    logic [idxBits-1:0]         resIdx;
    logic                       propagate;
    logic                       warmRun;
    logic                       calcRun;
    logic signed [outWidth-1:0] fwdPartial;
    logic signed [outWidth-1:0] bwdPartial;
    partialPair_t               wrPair;
    partialPair_t               rdPair;

    assign wrPair = '{fwd: fwdPartial, bwd: bwdPartial};

    batchSequencer sequencer (
        .clkDS     (clkDS),
        .rst       (rst),
        .wrAddr    (wrAddr),
        .lhAddr    (lhAddr),
        .brAddr    (brAddr),
        .frAddr    (frAddr),
        .resBank   (resBank),
        .resIdx    (resIdx),
        .propagate (propagate),
        .warmRun   (warmRun),
        .calcRun   (calcRun),
        .valid     (valid)
    );

    sampleStore samples (
        .clkDS  (clkDS),
        .wrAddr (wrAddr),
        .wrData (controlBits),
        .lhAddr (lhAddr),
        .brAddr (brAddr),
        .frAddr (frAddr),
        .lhData (lhSample),
        .brData (brSample),
        .frData (frSample)
    );

    lookaheadRecursion aheadRec (
        .clkDS      (clkDS),
        .rst        (rst),
        .warmRun    (warmRun),
        .calcRun    (calcRun),
        .propagate  (propagate),
        .lhSample   (lhSample),
        .brSample   (brSample),
        .bwdPartial (bwdPartial)
    );

    lookbackRecursion backRec (
        .clkDS      (clkDS),
        .rst        (rst),
        .calcRun    (calcRun),
        .frSample   (frSample),
        .fwdPartial (fwdPartial)
    );

    partialResultStore results (
        .clkDS   (clkDS),
        .resBank (resBank),
        .resIdx  (resIdx),
        .wrPair  (wrPair),
        .rdPair  (rdPair)
    );

    estimateCombiner combiner (
        .clkDS    (clkDS),
        .rst      (rst),
        .rdPair   (rdPair),
        .estimate (estimate)
    );

endmodule

/* src/estimateCombiner.sv */
`timescale 1ns/1ps

module estimateCombiner
    import batchEstimatorPkg::*;
(
    input  logic                clkDS,
    input  logic                rst,
    input  partialPair_t        rdPair,
    output logic [outWidth-1:0] estimate
);

    logic signed [stateWidth-1:0] sum;
    logic signed [outWidth-1:0]   sumSat;

    assign sum = $signed(rdPair.fwd) + $signed(rdPair.bwd);
    assign sumSat = satToOut(sum);

    // Offset binary out
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            estimate <= '0;
        end else begin
            estimate <= {~sumSat[outWidth-1], sumSat[outWidth-2:0]};
        end
    end

endmodule

/* src/partialResultStore.sv */
`timescale 1ns/1ps

module partialResultStore
    import batchEstimatorPkg::*;
(
    input  logic               clkDS,
    input  logic               resBank,
    input  logic [idxBits-1:0] resIdx,
    input  partialPair_t       wrPair,
    output partialPair_t       rdPair
);

    // Ping-pong banks, {bank, idx}
    logic signed [outWidth-1:0] fwdMem [2 * batchLen];
    logic signed [outWidth-1:0] bwdMem [2 * batchLen];
    logic [idxBits-1:0]         fwdIdx;

    // resIdx counts down, so the forward index is its mirror
    assign fwdIdx = idxBits'(batchLen - 1) - resIdx;

    // Backward partial lands in forward order
    always_ff @(posedge clkDS) begin
        fwdMem[{resBank, fwdIdx}] <= wrPair.fwd;
        bwdMem[{resBank, resIdx}] <= wrPair.bwd;
    end

    // Previous batch out of the idle bank
    always_ff @(posedge clkDS) begin
        rdPair.fwd <= fwdMem[{~resBank, fwdIdx}];
        rdPair.bwd <= bwdMem[{~resBank, fwdIdx}];
    end

endmodule

/* src/lookaheadRecursion.sv */
`timescale 1ns/1ps

module lookaheadRecursion
    import batchEstimatorPkg::*;
(
    input  logic                       clkDS,
    input  logic                       rst,
    input  logic                       warmRun,
    input  logic                       calcRun,
    input  logic                       propagate,
    input  logic [numCtrl-1:0]         lhSample,
    input  logic [numCtrl-1:0]         brSample,
    output logic signed [outWidth-1:0] bwdPartial
);

    logic signed [stateWidth-1:0] warmState;
    logic signed [stateWidth-1:0] warmNext;
    logic signed [stateWidth-1:0] mainState;
    logic signed [stateWidth-1:0] mainNext;

    assign warmNext = recurseStep(warmState, bwdPole, bwdGain, lhSample);
    assign mainNext = recurseStep(mainState, bwdPole, bwdGain, brSample);

    // Warm-up chain runs over the following batch, reversed
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            warmState <= '0;
        end else if (!warmRun || propagate) begin
            // Next cycle starts a new batch from zero
            warmState <= '0;
        end else begin
            warmState <= warmNext;
        end
    end

    // Main chain, seeded from the warm-up at each batch end
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            mainState <= '0;
        end else if (warmRun && propagate) begin
            mainState <= warmNext;
        end else if (calcRun) begin
            mainState <= mainNext;
        end else begin
            mainState <= '0;
        end
    end

    // Output includes the current sample
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            bwdPartial <= '0;
        end else if (calcRun) begin
            bwdPartial <= scaleSat(mainNext);
        end else begin
            bwdPartial <= '0;
        end
    end

endmodule

/* src/lookbackRecursion.sv */
`timescale 1ns/1ps

module lookbackRecursion
    import batchEstimatorPkg::*;
(
    input  logic                       clkDS,
    input  logic                       rst,
    input  logic                       calcRun,
    input  logic [numCtrl-1:0]         frSample,
    output logic signed [outWidth-1:0] fwdPartial
);

    logic signed [stateWidth-1:0] fwdState;
    logic signed [stateWidth-1:0] fwdNext;

    assign fwdNext = recurseStep(fwdState, fwdPole, fwdGain, frSample);

    // State runs on across batches
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            fwdState <= '0;
            fwdPartial <= '0;
        end else begin
            // Estimate uses the state before this sample
            fwdPartial <= scaleSat(fwdState);
            if (calcRun) begin
                fwdState <= fwdNext;
            end else begin
                fwdState <= '0;
            end
        end
    end

endmodule

/* src/sampleStore.sv */
`timescale 1ns/1ps

module sampleStore
    import batchEstimatorPkg::*;
(
    input  logic               clkDS,
    input  sampleAddr_t        wrAddr,
    input  logic [numCtrl-1:0] wrData,
    input  sampleAddr_t        lhAddr,
    input  sampleAddr_t        brAddr,
    input  sampleAddr_t        frAddr,
    output logic [numCtrl-1:0] lhData,
    output logic [numCtrl-1:0] brData,
    output logic [numCtrl-1:0] frData
);

    // Four batches in a circle, addressed as {bank, idx}
    logic [numCtrl-1:0] mem [(1 << bankBits) * batchLen];

    // A new sample lands every cycle
    always_ff @(posedge clkDS) begin
        mem[wrAddr] <= wrData;
    end

    // Lookahead, backward and forward reads
    always_ff @(posedge clkDS) begin
        lhData <= mem[lhAddr];
        brData <= mem[brAddr];
        frData <= mem[frAddr];
    end

endmodule

/* src/batchSequencer.sv */
`timescale 1ns/1ps

module batchSequencer
    import batchEstimatorPkg::*;
(
    input  logic               clkDS,
    input  logic               rst,
    output sampleAddr_t        wrAddr,
    output sampleAddr_t        lhAddr,
    output sampleAddr_t        brAddr,
    output sampleAddr_t        frAddr,
    output logic               resBank,
    output logic [idxBits-1:0] resIdx,
    output logic               propagate,
    output logic               warmRun,
    output logic               calcRun,
    output logic               valid
);

    logic [idxBits-1:0]  idx;
    logic [idxBits-1:0]  revIdx;
    logic [bankBits-1:0] bank;
    logic [2:0]          period;
    phase_e              phase;
    logic                lastIdx;
    logic                outRun;
    logic                resBankDly;
    logic [idxBits-1:0]  resIdxDly;
    logic [2:0]          validDly;

    assign lastIdx = (idx == idxBits'(batchLen - 1));
    assign revIdx = idxBits'(batchLen - 1) - idx;
    assign outRun = (phase == phRun);

    // Sample index, bank pointer and saturating period count
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            idx <= '0;
            bank <= '0;
            period <= '0;
            phase <= phFill;
        end else begin
            if (lastIdx) begin
                idx <= '0;
                bank <= bank + 1'b1;
                if (period != 3'd4) begin
                    period <= period + 1'b1;
                end
            end else begin
                idx <= idx + 1'b1;
            end
            // Output starts with period 4
            if (lastIdx && period == 3'd3) begin
                phase <= phRun;
            end
        end
    end

    // Read addresses go out one cycle ahead of their consumers
    assign wrAddr = '{bank: bank, idx: idx};
    assign lhAddr = '{bank: bankBits'(bank - 1'b1), idx: revIdx};
    // Three banks behind is one ahead modulo 4
    assign brAddr = '{bank: bankBits'(bank + 1'b1), idx: revIdx};
    assign frAddr = '{bank: bankBits'(bank + 1'b1), idx: idx};

    // Controls aligned to the recursion, result store and output stages
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            propagate <= 1'b0;
            warmRun <= 1'b0;
            calcRun <= 1'b0;
            resBankDly <= 1'b0;
            resBank <= 1'b0;
            resIdxDly <= '0;
            resIdx <= '0;
            validDly <= '0;
            valid <= 1'b0;
        end else begin
            propagate <= lastIdx;
            warmRun <= (period >= 3'd2);
            calcRun <= (period >= 3'd3);
            // Bank parity keeps toggling after the period count saturates
            resBankDly <= bank[0];
            resBank <= resBankDly;
            resIdxDly <= revIdx;
            resIdx <= resIdxDly;
            validDly <= {validDly[1:0], outRun};
            valid <= validDly[2];
        end
    end

    propagatePulse: assert property (@(posedge clkDS) disable iff (!rst)
        propagate |=> !propagate)
        else $error("propagate held for more than one cycle");

    validHold: assert property (@(posedge clkDS) disable iff (!rst)
        valid |=> valid)
        else $error("valid dropped after rising");

endmodule

/* src/batchEstimatorPkg.sv */
package batchEstimatorPkg;

    // Sizes
    localparam int numCtrl = 2;
    localparam int batchLen = 16;
    localparam int bankBits = 2;
    localparam int idxBits = 4;
    localparam int stateWidth = 20;
    localparam int fracBits = 10;
    localparam int outWidth = 12;
    localparam int scaleShift = 6;
    localparam int poleWidth = fracBits + 2;

    // Input sample to estimate, in clkDS cycles
    localparam int estimateLatency = 4 * batchLen + 4;

    // Limits of the signed estimate range, held at state width
    localparam logic signed [stateWidth-1:0] outMax = (1 <<< (outWidth - 1)) - 1;
    localparam logic signed [stateWidth-1:0] outMin = -(1 <<< (outWidth - 1));

    // First-order coefficients, poles in Q10
    localparam logic signed [poleWidth-1:0] fwdPole = 12'sd870;
    localparam logic signed [poleWidth-1:0] bwdPole = 12'sd900;
    localparam logic [numCtrl-1:0][stateWidth-1:0] fwdGain = {20'sd8000, 20'sd16000};
    localparam logic [numCtrl-1:0][stateWidth-1:0] bwdGain = {20'sd7000, 20'sd14000};

    typedef enum logic {
        phFill,
        phRun
    } phase_e;

    typedef struct packed {
        logic [bankBits-1:0] bank;
        logic [idxBits-1:0]  idx;
    } sampleAddr_t;

    typedef struct packed {
        logic signed [outWidth-1:0] fwd;
        logic signed [outWidth-1:0] bwd;
    } partialPair_t;

    // Clamp to the signed outWidth range
    function automatic logic signed [outWidth-1:0] satToOut(
        input logic signed [stateWidth-1:0] value
    );
        if (value > outMax) begin
            return outMax[outWidth-1:0];
        end else if (value < outMin) begin
            return outMin[outWidth-1:0];
        end
        return value[outWidth-1:0];
    endfunction

    function automatic logic signed [outWidth-1:0] scaleSat(
        input logic signed [stateWidth-1:0] state
    );
        return satToOut(state >>> scaleShift);
    endfunction

    // One recursion step; the sum wraps to the state width
    function automatic logic signed [stateWidth-1:0] recurseStep(
        input logic signed [stateWidth-1:0] state,
        input logic signed [poleWidth-1:0] pole,
        input logic [numCtrl-1:0][stateWidth-1:0] gain,
        input logic [numCtrl-1:0] ctrl
    );
        logic signed [stateWidth+poleWidth-1:0] prod;
        logic signed [stateWidth+poleWidth-1:0] acc;
        prod = state * pole;
        acc = prod >>> fracBits;
        for (int k = 0; k < numCtrl; k++) begin
            // Control bit 1 pushes up, 0 pushes down
            if (ctrl[k]) begin
                acc = acc + $signed(gain[k]);
            end else begin
                acc = acc - $signed(gain[k]);
            end
        end
        return acc[stateWidth-1:0];
    endfunction

endpackage
